/* Bender.yml */
package:
  name: fpu_wrap

sources:
  # Packages first, then the stages and the top level
  - files:
      - hdl/fpu_isa_pkg.sv
      - hdl/fpu_uarch_pkg.sv
      - hdl/fpu_op_decode.sv
      - hdl/fpu_noncomp_pipe.sv
      - hdl/fpu_wb_credit.sv
      - hdl/fpu_wrap_top.sv
  - target: test
    files:
      - verification/fpu_wrap_props.sv
      - verification/fpu_wrap_tb.sv

/* hdl/fpu_isa_pkg.sv */
// Instruction-level encoding of the FP32 non-computational operations
package fpu_isa_pkg;

    // --------------------
    // FP32 field layout
    // --------------------
    localparam int unsigned SIGN_BIT = 31;   // Sign position
    localparam int unsigned EXP_BITS = 8;    // Exponent width
    localparam int unsigned MAN_BITS = 23;   // Mantissa width, quiet bit on top

    typedef logic [31:0] fp32_t;             // Single-precision operand
    typedef logic [2:0]  rnd_field_t;        // Raw rm field from the instruction
    typedef logic [1:0]  sub_op_t;           // rm with the high bit masked off

    // Quiet NaN returned by min/max when both inputs are NaN
    localparam fp32_t CANONICAL_NAN = 32'h7fc0_0000;

    // Core operation codes as seen by the issue port
    typedef enum logic [2:0] {
        FNOP     = 3'd0,                     // No recoding, behaves as passthrough
        FSGNJ    = 3'd1,
        FMIN_MAX = 3'd2,
        FCMP     = 3'd3,
        FMV_F2X  = 3'd4,                     // FPR to GPR move
        FMV_X2F  = 3'd5                      // GPR to FPR move
    } fpu_operation_e;

    // Unit opcodes of the execute stage
    typedef enum logic [1:0] {
        SGNJ   = 2'd0,
        MINMAX = 2'd1,
        CMP    = 2'd2
    } fpu_unit_op_e;

    // --------------------
    // Sub-operations
    // --------------------
    // Sign injection
    localparam sub_op_t SUB_OP_SGNJ  = 2'd0;
    localparam sub_op_t SUB_OP_SGNJN = 2'd1;
    localparam sub_op_t SUB_OP_SGNJX = 2'd2;
    localparam sub_op_t SUB_OP_PASS  = 2'd3; // Moves land here too
    // Min/max
    localparam sub_op_t SUB_OP_MIN   = 2'd0;
    localparam sub_op_t SUB_OP_MAX   = 2'd1;
    // Compare
    localparam sub_op_t SUB_OP_LE    = 2'd0;
    localparam sub_op_t SUB_OP_LT    = 2'd1;
    localparam sub_op_t SUB_OP_EQ    = 2'd2;

endpackage

/* hdl/fpu_noncomp_pipe.sv */
// Two-stage FP32 execute unit for sign injection, min/max and compares
`timescale 1ns/1ns

module fpu_noncomp_pipe (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     in_valid_i,
    input  fpu_uarch_pkg::fpu_req_t  in_req_i,
    output logic                     out_valid_o,
    output fpu_uarch_pkg::fpu_resp_t out_resp_o
);

    // Operand class bits computed ahead of stage 1
    typedef struct packed {
        logic is_nan;
        logic is_snan;
        logic is_zero;
    } op_class_t;

    function automatic op_class_t classify(fpu_isa_pkg::fp32_t x);
        logic      exp_ones;
        logic      exp_zero;
        logic      man_zero;
        op_class_t c;
        exp_ones  = &x[fpu_isa_pkg::MAN_BITS +: fpu_isa_pkg::EXP_BITS];
        exp_zero  = ~|x[fpu_isa_pkg::MAN_BITS +: fpu_isa_pkg::EXP_BITS];
        man_zero  = ~|x[fpu_isa_pkg::MAN_BITS-1:0];
        c.is_nan  = exp_ones & ~man_zero;
        c.is_snan = c.is_nan & ~x[fpu_isa_pkg::MAN_BITS-1];  // Quiet bit clear
        c.is_zero = exp_zero & man_zero;                     // Either sign
        return c;
    endfunction

    logic [fpu_uarch_pkg::EXEC_LATENCY-1:0] valid_q;  // One bit per stage

    fpu_uarch_pkg::fpu_req_t  s1_req_q;
    op_class_t                cls_a_q, cls_b_q;
    fpu_uarch_pkg::fpu_resp_t s2_resp_q;

    fpu_isa_pkg::fp32_t op_a, op_b;
    logic               sign_a, sign_b;
    logic               any_nan, any_snan;
    logic               mag_lt, mag_gt;
    logic               lt_total;                // -0 below +0, for min/max
    logic               lt_ord;                  // IEEE ordering, zeros equal
    logic               eq_ord;
    fpu_isa_pkg::fp32_t res_d;
    logic               nv_d;

    // --------------------
    // Stage 1
    // --------------------
    always_ff @(posedge clk_i) begin : stage1_regs
        if (in_valid_i) begin
            s1_req_q <= in_req_i;
            cls_a_q  <= classify(in_req_i.operand_a);
            cls_b_q  <= classify(in_req_i.operand_b);
        end
    end

    // --------------------
    // Stage 2 datapath
    // --------------------
    assign op_a     = s1_req_q.operand_a;
    assign op_b     = s1_req_q.operand_b;
    assign sign_a   = op_a[fpu_isa_pkg::SIGN_BIT];
    assign sign_b   = op_b[fpu_isa_pkg::SIGN_BIT];
    assign any_nan  = cls_a_q.is_nan | cls_b_q.is_nan;
    assign any_snan = cls_a_q.is_snan | cls_b_q.is_snan;
    assign mag_lt   = op_a[fpu_isa_pkg::SIGN_BIT-1:0] < op_b[fpu_isa_pkg::SIGN_BIT-1:0];
    assign mag_gt   = op_a[fpu_isa_pkg::SIGN_BIT-1:0] > op_b[fpu_isa_pkg::SIGN_BIT-1:0];
    // Sign-magnitude order, negative magnitudes reversed
    assign lt_total = (sign_a != sign_b) ? sign_a : (sign_a ? mag_gt : mag_lt);
    assign lt_ord   = lt_total & ~(cls_a_q.is_zero & cls_b_q.is_zero);
    assign eq_ord   = (op_a == op_b) | (cls_a_q.is_zero & cls_b_q.is_zero);

    always_comb begin : stage2_compute
        res_d = '0;                              // Unused encodings give 0, no flags
        nv_d  = 1'b0;
        case (s1_req_q.unit_op)
            fpu_isa_pkg::SGNJ: begin
                case (s1_req_q.sub_op)
                    fpu_isa_pkg::SUB_OP_SGNJ:  res_d = {sign_b, op_a[30:0]};
                    fpu_isa_pkg::SUB_OP_SGNJN: res_d = {~sign_b, op_a[30:0]};
                    fpu_isa_pkg::SUB_OP_SGNJX: res_d = {sign_a ^ sign_b, op_a[30:0]};
                    default:                   res_d = op_a;  // Passthrough and moves
                endcase
            end
            fpu_isa_pkg::MINMAX: begin
                if (s1_req_q.sub_op == fpu_isa_pkg::SUB_OP_MIN ||
                    s1_req_q.sub_op == fpu_isa_pkg::SUB_OP_MAX) begin
                    nv_d = any_snan;
                    if (cls_a_q.is_nan && cls_b_q.is_nan) begin
                        res_d = fpu_isa_pkg::CANONICAL_NAN;
                    end else if (cls_a_q.is_nan) begin
                        res_d = op_b;            // NaN loses to a number
                    end else if (cls_b_q.is_nan) begin
                        res_d = op_a;
                    end else if ((s1_req_q.sub_op == fpu_isa_pkg::SUB_OP_MIN) == lt_total) begin
                        res_d = op_a;
                    end else begin
                        res_d = op_b;
                    end
                end
            end
            fpu_isa_pkg::CMP: begin
                case (s1_req_q.sub_op)
                    fpu_isa_pkg::SUB_OP_LE: begin
                        nv_d  = any_nan;         // Signaling compare
                        res_d = {31'd0, ~any_nan & (lt_ord | eq_ord)};
                    end
                    fpu_isa_pkg::SUB_OP_LT: begin
                        nv_d  = any_nan;
                        res_d = {31'd0, ~any_nan & lt_ord};
                    end
                    fpu_isa_pkg::SUB_OP_EQ: begin
                        nv_d  = any_snan;        // Quiet compare
                        res_d = {31'd0, ~any_nan & eq_ord};
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    // Stage 2 result register
    always_ff @(posedge clk_i) begin : stage2_regs
        if (valid_q[0]) begin
            s2_resp_q.result <= res_d;
            s2_resp_q.status <= '{nv: nv_d, default: 1'b0};
            s2_resp_q.tag    <= s1_req_q.tag;
        end
    end

    // Per-stage valid, pipe never stalls
    always_ff @(posedge clk_i or negedge rst_ni) begin : valid_regs
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[fpu_uarch_pkg::EXEC_LATENCY-2:0], in_valid_i};
        end
    end

    assign out_valid_o = valid_q[fpu_uarch_pkg::EXEC_LATENCY-1];
    assign out_resp_o  = s2_resp_q;

endmodule

/* hdl/fpu_op_decode.sv */
// Decode stage: operation translation and valid/ready to unit handshake inversion
`timescale 1ns/1ns

module fpu_op_decode (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    // Issue port
    input  logic                        req_valid_i,
    output logic                        req_ready_o,
    input  fpu_isa_pkg::fpu_operation_e operation_i,
    input  fpu_isa_pkg::rnd_field_t     rm_i,
    input  fpu_isa_pkg::fp32_t          operand_a_i,
    input  fpu_isa_pkg::fp32_t          operand_b_i,
    input  fpu_uarch_pkg::trans_id_t    trans_id_i,
    // Unit input handshake
    input  logic                        credit_avail_i,
    output logic                        unit_valid_o,
    output fpu_uarch_pkg::fpu_req_t     unit_req_o
);

    typedef enum logic {
        READY,                                   // Requests pass straight through
        STALL                                    // Held request waits for a credit
    } state_e;

    state_e state_q, state_d;

    fpu_uarch_pkg::fpu_req_t req_d;              // Live decoded request
    fpu_uarch_pkg::fpu_req_t hold_q;             // Captured request during a stall

    logic hold_inputs;                           // Capture strobe
    logic use_hold;                              // Unit reads from the hold register

    // --------------------
    // Input translation
    // --------------------
    always_comb begin : input_translation
        // Defaults match a sign-injection passthrough
        req_d.unit_op   = fpu_isa_pkg::SGNJ;
        req_d.sub_op    = fpu_isa_pkg::SUB_OP_PASS;
        req_d.operand_a = operand_a_i;
        req_d.operand_b = operand_b_i;
        req_d.tag       = trans_id_i;

        case (operation_i)
            // Sub-op in rm, bit 2 masked
            fpu_isa_pkg::FSGNJ: begin
                req_d.unit_op = fpu_isa_pkg::SGNJ;
                req_d.sub_op  = rm_i[1:0];
            end
            fpu_isa_pkg::FMIN_MAX: begin
                req_d.unit_op = fpu_isa_pkg::MINMAX;
                req_d.sub_op  = rm_i[1:0];       // 0 min, 1 max
            end
            fpu_isa_pkg::FCMP: begin
                req_d.unit_op = fpu_isa_pkg::CMP;
                req_d.sub_op  = rm_i[1:0];       // 0 le, 1 lt, 2 eq
            end
            // No recoding between register files, just pass operand a
            fpu_isa_pkg::FMV_F2X,
            fpu_isa_pkg::FMV_X2F: begin
                req_d.unit_op = fpu_isa_pkg::SGNJ;
                req_d.sub_op  = fpu_isa_pkg::SUB_OP_PASS;
            end
            default: ;                           // FNOP keeps the passthrough defaults
        endcase
    end

    // --------------------
    // Protocol inversion FSM
    // --------------------
    always_comb begin : input_fsm
        req_ready_o  = 1'b0;
        unit_valid_o = 1'b0;
        hold_inputs  = 1'b0;
        use_hold     = 1'b0;
        state_d      = state_q;

        case (state_q)
            READY: begin
                req_ready_o  = credit_avail_i | ~req_valid_i;
                unit_valid_o = req_valid_i;      // Forward live request
                // No slot downstream, park the request
                if (req_valid_i && !credit_avail_i) begin
                    hold_inputs = 1'b1;
                    state_d     = STALL;
                end
            end
            STALL: begin
                unit_valid_o = 1'b1;             // Held item always pending
                use_hold     = 1'b1;
                // Item enters this cycle, acknowledge it upstream
                if (credit_avail_i) begin
                    req_ready_o = 1'b1;
                    state_d     = READY;
                end
            end
            default: state_d = READY;
        endcase
    end

    // State register
    always_ff @(posedge clk_i or negedge rst_ni) begin : state_reg
        if (!rst_ni) begin
            state_q <= READY;
        end else begin
            state_q <= state_d;
        end
    end

    // Hold buffer, written only on entry to STALL
    always_ff @(posedge clk_i) begin : hold_reg
        if (hold_inputs) begin
            hold_q <= req_d;
        end
    end

    assign unit_req_o = use_hold ? hold_q : req_d;  // Held copy wins while stalling

endmodule

/* hdl/fpu_uarch_pkg.sv */
// Microarchitecture of the FPU wrapper: widths, latency, credits and transfer structs
package fpu_uarch_pkg;

    // --------------------
    // Widths and sizing
    // --------------------
    localparam int unsigned TRANS_ID_BITS = 3;   // Tag width of the issue port
    localparam int unsigned EXEC_LATENCY  = 2;   // Execute pipe depth
    localparam int unsigned NUM_CREDITS   = 4;   // Downstream slots

    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

    // Counter must also hold the full value
    typedef logic [$clog2(NUM_CREDITS+1)-1:0] credit_cnt_t;

    // Exception flags in RISC-V fflags order
    typedef struct packed {
        logic nv;                                // Invalid operation
        logic dz;                                // Divide by zero, never set here
        logic of;                                // Overflow, never set here
        logic uf;                                // Underflow, never set here
        logic nx;                                // Inexact, never set here
    } status_t;

    // --------------------
    // Transfer structs
    // --------------------
    // Decoded request into the execute pipe, 71 bits
    typedef struct packed {
        fpu_isa_pkg::fpu_unit_op_e unit_op;
        fpu_isa_pkg::sub_op_t      sub_op;
        fpu_isa_pkg::fp32_t        operand_a;
        fpu_isa_pkg::fp32_t        operand_b;
        trans_id_t                 tag;
    } fpu_req_t;

    // Response out of the execute pipe, 40 bits
    typedef struct packed {
        fpu_isa_pkg::fp32_t result;
        status_t            status;
        trans_id_t          tag;
    } fpu_resp_t;

endpackage

/* hdl/fpu_wb_credit.sv */
// Result stage: downstream credit counter and registered response port
`timescale 1ns/1ns

module fpu_wb_credit (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     entry_i,          // Item enters the pipe
    input  logic                     credit_return_i,  // Receiver freed one slot
    output logic                     credit_avail_o,
    input  logic                     pipe_valid_i,
    input  fpu_uarch_pkg::fpu_resp_t pipe_resp_i,
    output logic                     resp_valid_o,
    output fpu_uarch_pkg::fpu_resp_t resp_o
);

    localparam fpu_uarch_pkg::credit_cnt_t CREDITS_FULL =
        fpu_uarch_pkg::credit_cnt_t'(fpu_uarch_pkg::NUM_CREDITS);

    fpu_uarch_pkg::credit_cnt_t credit_q;
    logic                       resp_valid_q;
    fpu_uarch_pkg::fpu_resp_t   resp_q;

    // --------------------
    // Credit counter
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : credit_reg
        if (!rst_ni) begin
            credit_q <= CREDITS_FULL;            // All slots free out of reset
        end else begin
            case ({entry_i, credit_return_i})
                2'b10: if (credit_q != '0) credit_q <= credit_q - 1'b1;
                2'b01: if (credit_q != CREDITS_FULL) credit_q <= credit_q + 1'b1;
                default: ;                       // Both or neither, count unchanged
            endcase
        end
    end

    assign credit_avail_o = (credit_q != '0);

    // --------------------
    // Response port
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : resp_valid_reg
        if (!rst_ni) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= pipe_valid_i;        // Single-cycle pulse per item
        end
    end

    always_ff @(posedge clk_i) begin : resp_reg
        if (pipe_valid_i) begin
            resp_q <= pipe_resp_i;
        end
    end

    assign resp_valid_o = resp_valid_q;
    assign resp_o       = resp_q;

endmodule

/* hdl/fpu_wrap_top.sv */
// FPU wrapper top: decode, execute and result stages with credit-based output
`timescale 1ns/1ns

module fpu_wrap_top (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    // Issue side
    input  logic                        req_valid_i,
    output logic                        req_ready_o,
    input  fpu_isa_pkg::fpu_operation_e operation_i,
    input  fpu_isa_pkg::rnd_field_t     rm_i,
    input  fpu_isa_pkg::fp32_t          operand_a_i,
    input  fpu_isa_pkg::fp32_t          operand_b_i,
    input  fpu_uarch_pkg::trans_id_t    trans_id_i,
    // Downstream side
    output logic                        resp_valid_o,
    output fpu_uarch_pkg::fpu_resp_t    resp_o,
    input  logic                        credit_return_i
);

    fpu_uarch_pkg::fpu_req_t  unit_req;
    logic                     unit_valid;
    logic                     credit_avail;      // Unit in-ready
    logic                     entry;
    fpu_uarch_pkg::fpu_resp_t pipe_resp;
    logic                     pipe_valid;

    // Handshake into the pipe, reserves a downstream slot
    assign entry = unit_valid & credit_avail;

    fpu_op_decode i_op_decode (
        .clk_i,
        .rst_ni,
        .req_valid_i,
        .req_ready_o,
        .operation_i,
        .rm_i,
        .operand_a_i,
        .operand_b_i,
        .trans_id_i,
        .credit_avail_i (credit_avail),
        .unit_valid_o   (unit_valid),
        .unit_req_o     (unit_req)
    );

    fpu_noncomp_pipe i_noncomp_pipe (
        .clk_i,
        .rst_ni,
        .in_valid_i  (entry),
        .in_req_i    (unit_req),
        .out_valid_o (pipe_valid),
        .out_resp_o  (pipe_resp)
    );

    fpu_wb_credit i_wb_credit (
        .clk_i,
        .rst_ni,
        .entry_i         (entry),
        .credit_return_i,
        .credit_avail_o  (credit_avail),
        .pipe_valid_i    (pipe_valid),
        .pipe_resp_i     (pipe_resp),
        .resp_valid_o,
        .resp_o
    );

endmodule

/* verification/fpu_wrap_props.sv */
// Protocol and credit assertions for the FPU wrapper top level
`timescale 1ns/1ns

module fpu_wrap_props (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       req_valid_i,
    input  logic                       req_ready_i,
    input  fpu_uarch_pkg::fpu_req_t    unit_req_i,     // Request seen by the pipe
    input  logic                       entry_i,        // Item enters the pipe
    input  logic                       credit_return_i, // Receiver frees a slot
    input  fpu_uarch_pkg::credit_cnt_t credit_cnt_i,
    input  logic                       resp_valid_i
);

    // --------------------
    // Credit counter
    // --------------------
    // A returned credit on a full counter would push it past the slot count
    credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (credit_return_i && !entry_i) |-> credit_cnt_i < fpu_uarch_pkg::NUM_CREDITS)
        else $error("Credit counter would exceed the number of downstream slots");

    // Stalled request must reach the pipe unchanged
    hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (req_valid_i && !req_ready_i) |=> $stable(unit_req_i))
        else $error("Held request changed during a stall");

    // --------------------
    // Response origin
    // --------------------
    // Fixed path: two pipe stages plus the output register
    resp_after_entry: assert property (@(posedge clk_i) disable iff (!rst_ni)
        resp_valid_i |-> $past(entry_i, fpu_uarch_pkg::EXEC_LATENCY + 1))
        else $error("Response valid without a matching pipe entry");

endmodule

/* verification/fpu_wrap_tb.sv */
// Testbench for the FPU wrapper: directed and random issue, credit model, reference checks
`timescale 1ns/1ns

module fpu_wrap_tb;

    localparam int unsigned CLK_PERIOD = 4;
    localparam int unsigned N_DIRECTED = 14;
    localparam int unsigned N_RANDOM   = 60;
    localparam int unsigned N_BURST    = fpu_uarch_pkg::NUM_CREDITS + 2;  // Overruns the slots
    localparam int unsigned NUM_REQ    = N_DIRECTED + N_RANDOM + N_BURST;

    logic                        clk_i = 1'b0;
    logic                        rst_ni;
    logic                        req_valid_i;
    logic                        req_ready_o;
    fpu_isa_pkg::fpu_operation_e operation_i;
    fpu_isa_pkg::rnd_field_t     rm_i;
    fpu_isa_pkg::fp32_t          operand_a_i, operand_b_i;
    fpu_uarch_pkg::trans_id_t    trans_id_i;
    logic                        resp_valid_o;
    fpu_uarch_pkg::fpu_resp_t    resp_o;
    logic                        credit_return_i;

    fpu_uarch_pkg::fpu_resp_t exp_q[$];          // Expected responses, issue order
    fpu_uarch_pkg::trans_id_t next_tag    = '0;
    logic [31:0]              stim_seed   = 32'hfeee;
    logic [31:0]              credit_seed = 32'hfeee;  // Own stream for the receiver
    int                       outstanding = 0;   // Accepted, credit not yet back
    int                       pending     = 0;   // Received, credit still owed
    int                       resp_count  = 0;
    logic                     credits_on  = 1'b1;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    fpu_wrap_top dut (.*);

    bind fpu_wrap_top fpu_wrap_props props (
        .clk_i, .rst_ni, .req_valid_i,
        .req_ready_i     (req_ready_o),
        .unit_req_i      (unit_req),
        .entry_i         (entry),
        .credit_return_i (credit_return_i),
        .credit_cnt_i    (i_wb_credit.credit_q),
        .resp_valid_i    (resp_valid_o)
    );

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Mostly plain values, some zeros, quiet and signaling NaNs
    function automatic fpu_isa_pkg::fp32_t pick_operand(input logic [31:0] r);
        case (r[31:29])
            3'd0:    return {r[0], 31'd0};
            3'd1:    return {r[0], 8'hff, 1'b1, r[21:0]};
            3'd2:    return {r[0], 8'hff, 1'b0, r[21:1], 1'b1};  // Mantissa kept nonzero
            3'd3:    return {r[0], 8'h7f, r[22:0]};              // Near one, close values
            default: return r;
        endcase
    endfunction

    // Expected response from the operation rules
    function automatic fpu_uarch_pkg::fpu_resp_t ref_model(
        input fpu_isa_pkg::fpu_operation_e op, input fpu_isa_pkg::rnd_field_t rm,
        input fpu_isa_pkg::fp32_t a, input fpu_isa_pkg::fp32_t b,
        input fpu_uarch_pkg::trans_id_t tag);
        fpu_uarch_pkg::fpu_resp_t r;
        logic [1:0]  sub;
        logic        a_nan, b_nan, a_snan, b_snan, any_nan, zeros, a_below;
        logic [31:0] key_a, key_b;
        r       = '0;
        r.tag   = tag;
        sub     = rm[1:0];                       // rm bit 2 never matters
        a_nan   = (a[30:23] == 8'hff) && (a[22:0] != '0);
        b_nan   = (b[30:23] == 8'hff) && (b[22:0] != '0);
        a_snan  = a_nan && !a[22];
        b_snan  = b_nan && !b[22];
        any_nan = a_nan || b_nan;
        zeros   = (a[30:0] == '0) && (b[30:0] == '0);
        // Sign-magnitude onto unsigned order, -0 lands just below +0
        key_a   = a[31] ? ~a : (a | 32'h8000_0000);
        key_b   = b[31] ? ~b : (b | 32'h8000_0000);
        a_below = key_a < key_b;
        case (op)
            fpu_isa_pkg::FSGNJ: begin
                case (sub)
                    2'd0:    r.result = {b[31], a[30:0]};
                    2'd1:    r.result = {~b[31], a[30:0]};
                    2'd2:    r.result = {a[31] ^ b[31], a[30:0]};
                    default: r.result = a;
                endcase
            end
            fpu_isa_pkg::FMIN_MAX: begin
                if (sub < 2'd2) begin
                    r.status.nv = a_snan || b_snan;
                    if (a_nan && b_nan)  r.result = fpu_isa_pkg::CANONICAL_NAN;
                    else if (a_nan)      r.result = b;
                    else if (b_nan)      r.result = a;
                    else if (sub == 2'd0) r.result = a_below ? a : b;
                    else                 r.result = a_below ? b : a;
                end
            end
            fpu_isa_pkg::FCMP: begin
                case (sub)
                    2'd0: begin
                        r.status.nv = any_nan;
                        r.result[0] = !any_nan && (key_a <= key_b || zeros);
                    end
                    2'd1: begin
                        r.status.nv = any_nan;
                        r.result[0] = !any_nan && a_below && !zeros;
                    end
                    2'd2: begin
                        r.status.nv = a_snan || b_snan;  // Quiet compare
                        r.result[0] = !any_nan && (a == b || zeros);
                    end
                    default: ;
                endcase
            end
            default: r.result = a;               // Moves and FNOP pass a through
        endcase
        return r;
    endfunction

    task automatic abort(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            abort($sformatf("FAILED at %0t ns: %s, got %0h expected %0h",
                            $time, what, got, exp));
        end
    endtask

    // --------------------
    // Stimulus
    // --------------------
    task automatic issue(input fpu_isa_pkg::fpu_operation_e op,
                         input fpu_isa_pkg::rnd_field_t rm,
                         input fpu_isa_pkg::fp32_t a, input fpu_isa_pkg::fp32_t b);
        logic rdy;
        @(negedge clk_i);
        req_valid_i = 1'b1;
        operation_i = op;
        rm_i        = rm;
        operand_a_i = a;
        operand_b_i = b;
        trans_id_i  = next_tag;
        rdy         = 1'b0;
        while (!rdy) begin
            #1;
            rdy = req_ready_o;                   // Stable until the next rising edge
            @(posedge clk_i);
            if (!rdy) @(negedge clk_i);
        end
        exp_q.push_back(ref_model(op, rm, a, b, next_tag));
        outstanding++;
        check_value(outstanding <= fpu_uarch_pkg::NUM_CREDITS, 1'b1, "outstanding count");
        next_tag++;
    endtask

    task automatic issue_random();
        fpu_isa_pkg::fpu_operation_e op;
        fpu_isa_pkg::rnd_field_t     rm;
        fpu_isa_pkg::fp32_t          a, b;
        stim_seed = lcg_next(stim_seed);
        op        = fpu_isa_pkg::fpu_operation_e'(3'(stim_seed[15:8] % 6));
        rm        = stim_seed[18:16];
        stim_seed = lcg_next(stim_seed);
        a         = pick_operand(stim_seed);
        stim_seed = lcg_next(stim_seed);
        b         = (stim_seed[7:4] == 4'd0) ? a : pick_operand(stim_seed);  // Some equal pairs
        issue(op, rm, a, b);
    endtask

    task automatic idle(input int unsigned n);
        repeat (n) begin
            @(negedge clk_i);
            req_valid_i = 1'b0;
        end
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0 || outstanding != 0) @(negedge clk_i);
    endtask

    // --------------------
    // Receiver and checker
    // --------------------
    always @(negedge clk_i) begin : compare_resp
        fpu_uarch_pkg::fpu_resp_t exp;
        if (rst_ni && resp_valid_o) begin
            if (exp_q.size() == 0) abort("Response arrived with no request outstanding");
            exp = exp_q.pop_front();
            check_value(resp_o, exp, $sformatf("response tag %0d", exp.tag));
            resp_count++;
            pending++;
        end
    end

    // Returns one credit per received response after a random delay
    always begin : credit_model
        int unsigned gap;
        @(posedge clk_i);
        if (credits_on && pending > 0) begin
            credit_seed = lcg_next(credit_seed);
            gap         = credit_seed[17:16];   // 0 to 3 extra cycles
            repeat (gap) @(negedge clk_i);
            @(negedge clk_i);
            credit_return_i = 1'b1;
            pending--;
            outstanding--;
            @(negedge clk_i);
            credit_return_i = 1'b0;
        end
    end

    initial begin : watchdog
        #((NUM_REQ * 20 + 4) * CLK_PERIOD);
        abort("Timeout: the run did not finish in the expected time");
    end

    initial begin : main_seq
        int burst_start;
        rst_ni          = 1'b0;
        req_valid_i     = 1'b0;
        operation_i     = fpu_isa_pkg::FNOP;
        rm_i            = '0;
        operand_a_i     = '0;
        operand_b_i     = '0;
        trans_id_i      = '0;
        credit_return_i = 1'b0;
        repeat (4) @(negedge clk_i);
        rst_ni = 1'b1;
        @(negedge clk_i);
        #1;
        check_value(resp_valid_o, 1'b0, "resp_valid_o after reset");
        check_value(req_ready_o, 1'b1, "req_ready_o after reset");

        // Sign injection, moves and rm bit 2
        issue(fpu_isa_pkg::FSGNJ,    3'd0, 32'h3f80_0000, 32'hc000_0000);
        issue(fpu_isa_pkg::FSGNJ,    3'd1, 32'hbf80_0000, 32'hc000_0000);
        issue(fpu_isa_pkg::FSGNJ,    3'd6, 32'hbf80_0000, 32'hc000_0000);
        issue(fpu_isa_pkg::FMV_F2X,  3'd0, 32'h8123_4567, 32'h0000_0000);
        issue(fpu_isa_pkg::FMV_X2F,  3'd2, 32'h7f80_0001, 32'hffff_ffff);
        issue(fpu_isa_pkg::FNOP,     3'd1, 32'hdead_beef, 32'h8000_0000);
        // Min/max on signed zeros, NaNs and unused sub-operations
        issue(fpu_isa_pkg::FMIN_MAX, 3'd0, 32'h0000_0000, 32'h8000_0000);
        issue(fpu_isa_pkg::FMIN_MAX, 3'd1, 32'h7fc0_0000, 32'h4000_0000);
        issue(fpu_isa_pkg::FMIN_MAX, 3'd0, 32'h7f80_0001, 32'h7fc0_0000);
        issue(fpu_isa_pkg::FMIN_MAX, 3'd3, 32'h3f80_0000, 32'h4000_0000);
        // Compares
        issue(fpu_isa_pkg::FCMP,     3'd2, 32'h8000_0000, 32'h0000_0000);
        issue(fpu_isa_pkg::FCMP,     3'd0, 32'h7fc0_0000, 32'h3f80_0000);
        issue(fpu_isa_pkg::FCMP,     3'd2, 32'hff80_0001, 32'h3f80_0000);
        issue(fpu_isa_pkg::FCMP,     3'd3, 32'h3f80_0000, 32'h3f80_0000);
        idle(1);

        // Random mix with random gaps
        repeat (N_RANDOM) begin
            issue_random();
            stim_seed = lcg_next(stim_seed);
            idle(stim_seed[25:24] % 3);
        end
        idle(1);
        wait_drained();

        // Withhold credits, the issue side must stall after the last slot
        credits_on  = 1'b0;
        burst_start = resp_count;
        fork
            begin
                repeat (N_BURST) issue_random();
                idle(1);
            end
            begin
                repeat (24) @(negedge clk_i);
                #1;
                check_value(resp_count - burst_start, fpu_uarch_pkg::NUM_CREDITS,
                            "responses while credits withheld");
                check_value(req_ready_o, 1'b0, "req_ready_o while credits withheld");
                credits_on = 1'b1;
            end
        join
        wait_drained();
        check_value(resp_count, NUM_REQ, "total responses");
        $display("Test passed");
        $finish;
    end

endmodule

/* vlog.f */
hdl/fpu_isa_pkg.sv
hdl/fpu_uarch_pkg.sv
hdl/fpu_op_decode.sv
hdl/fpu_noncomp_pipe.sv
hdl/fpu_wb_credit.sv
hdl/fpu_wrap_top.sv
verification/fpu_wrap_props.sv
verification/fpu_wrap_tb.sv
